// ==== sim.f ====
src/board_pkg.sv
src/ps2_rx.sv
src/key_decode.sv
src/input_merge.sv
src/board_config.sv
src/reset_stretch.sv
src/board_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_board_ctrl.sv

// ==== Bender.yml ====
package:
  name: board_ctrl

sources:
  - src/board_pkg.sv
  - src/ps2_rx.sv
  - src/key_decode.sv
  - src/input_merge.sv
  - src/board_config.sv
  - src/reset_stretch.sv
  - src/board_ctrl_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_board_ctrl.sv

// ==== verif/tb_board_ctrl.sv ====
// board control testbench: table-driven keyboard, joystick and reset scenarios with checks
`timescale 1ns/1ps

module tb_board_ctrl import board_pkg::*; ();

    localparam int N_ROWS      = 29;
    // a break code costs two frames of about 220 cycles
    localparam int CYCLE_LIMIT = N_ROWS * 400 + 2000;

    typedef enum logic [3:0] {
        ACT_JOY, ACT_JOY_RND, ACT_MAKE, ACT_BREAK, ACT_EXT,
        ACT_BAD, ACT_DIP, ACT_REQ, ACT_DL
    } act_e;

    // action, data, expected held keys {joy1, coin, start}, settings, reset rise
    typedef struct packed {
        act_e        act;
        logic [19:0] data;
        logic [13:0] kb;
        logic        pause;
        logic [3:0]  gfx;
        logic        rst_rise;
    } row_t;

    logic             clk_sys;
    logic             game_rst, downloading, rst_req, dip_flip;
    logic             ps2_clk, ps2_data;
    logic [JOY_W-1:0] board_joy1, board_joy2;
    game_in_t         game_in;
    logic             game_pause, core_rst;
    logic [3:0]       gfx_en;

    row_t tbl [0:N_ROWS-1];
    int   n_rows     = 0;
    int   errors     = 0;
    int   cycles     = 0;
    int   rise_cnt   = 0;
    logic core_rst_q = 1'b1;

    tb_clk_gen u_clk_gen (.clk_sys(clk_sys));

    board_ctrl_top UUT (.*);

    // run limit
    always @(posedge clk_sys) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // core_rst rising edges, sampled away from the active edge
    always @(negedge clk_sys) begin
        if (core_rst === 1'b1 && core_rst_q === 1'b0) rise_cnt++;
        core_rst_q = core_rst;
    end

    // merge rule: stick OR keys, coin/start {stick2, stick1}, then game polarity
    function automatic game_in_t merge_inputs(input logic [19:0] joy, input logic [13:0] kb);
        game_in_t g;
        g.joy1    = joy[9:0] | kb[13:4];
        g.joy2    = joy[19:10];
        g.coin    = {joy[17], joy[7]} | kb[3:2];
        g.start   = {joy[18], joy[8]} | kb[1:0];
        g.service = 1'b0;
        return g ^ {$bits(game_in_t){INPUTS_ACTIVE_LOW}};
    endfunction

    task automatic add_row(input act_e act, input logic [19:0] data, input logic [13:0] kb,
                           input logic pause, input logic [3:0] gfx, input logic rst_rise);
        tbl[n_rows] = {act, data, kb, pause, gfx, rst_rise};
        n_rows++;
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("Fail at %0t: %s expected %h got %h", $time, sig, exp, got);
        errors++;
    endtask

    // one 11-bit frame, data changes while ps2_clk is high
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int b = 0; b < 11; b++) begin
            ps2_data = frame[b];
            repeat (10) @(posedge clk_sys);
            #1;
            ps2_clk = 1'b0;
            repeat (10) @(posedge clk_sys);
            #1;
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    initial begin
        logic [19:0] joy;
        game_in_t    exp_in;
        int          rst_cnt;
        int          err_before;
        int          rise_before;
        int          ok_cnt;
        void'($urandom(45));
        game_rst    = 1'b1;
        downloading = 1'b0;
        rst_req     = 1'b0;
        dip_flip    = 1'b0;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        board_joy1  = '0;
        board_joy2  = '0;
        ok_cnt      = 0;
        // joystick path, random sticks with pause bits held low
        add_row(ACT_JOY_RND, 20'h0, 14'h000, 1'b0, 4'hF, 1'b0);
        add_row(ACT_JOY_RND, 20'h0, 14'h000, 1'b0, 4'hF, 1'b0);
        add_row(ACT_JOY_RND, 20'h0, 14'h000, 1'b0, 4'hF, 1'b0);
        add_row(ACT_JOY, 20'h0, 14'h000, 1'b0, 4'hF, 1'b0);
        // keyboard merge: W, coin 5, start 1, extended W ignored
        add_row(ACT_MAKE, SC_KEY_W, 14'h080, 1'b0, 4'hF, 1'b0);
        add_row(ACT_BREAK, SC_KEY_W, 14'h000, 1'b0, 4'hF, 1'b0);
        add_row(ACT_MAKE, SC_KEY_5, 14'h004, 1'b0, 4'hF, 1'b0);
        add_row(ACT_MAKE, SC_KEY_1, 14'h005, 1'b0, 4'hF, 1'b0);
        add_row(ACT_EXT, SC_KEY_W, 14'h005, 1'b0, 4'hF, 1'b0);
        add_row(ACT_BREAK, SC_KEY_5, 14'h001, 1'b0, 4'hF, 1'b0);
        add_row(ACT_BREAK, SC_KEY_1, 14'h000, 1'b0, 4'hF, 1'b0);
        // pause from key, then from stick 1 pause bit
        add_row(ACT_MAKE, SC_KEY_P, 14'h000, 1'b1, 4'hF, 1'b0);
        add_row(ACT_BREAK, SC_KEY_P, 14'h000, 1'b1, 4'hF, 1'b0);
        add_row(ACT_JOY, 20'h00200, 14'h000, 1'b0, 4'hF, 1'b0);
        add_row(ACT_JOY, 20'h0, 14'h000, 1'b0, 4'hF, 1'b0);
        // layer toggles
        add_row(ACT_MAKE, SC_KEY_F1, 14'h000, 1'b0, 4'hE, 1'b0);
        add_row(ACT_BREAK, SC_KEY_F1, 14'h000, 1'b0, 4'hE, 1'b0);
        add_row(ACT_MAKE, SC_KEY_F4, 14'h000, 1'b0, 4'h6, 1'b0);
        add_row(ACT_BREAK, SC_KEY_F4, 14'h000, 1'b0, 4'h6, 1'b0);
        add_row(ACT_MAKE, SC_KEY_F1, 14'h000, 1'b0, 4'h7, 1'b0);
        add_row(ACT_BREAK, SC_KEY_F1, 14'h000, 1'b0, 4'h7, 1'b0);
        // reset causes, settings must survive
        add_row(ACT_DIP, 20'h0, 14'h000, 1'b0, 4'h7, 1'b1);
        add_row(ACT_REQ, 20'h0, 14'h000, 1'b0, 4'h7, 1'b1);
        add_row(ACT_DL, 20'h0, 14'h000, 1'b0, 4'h7, 1'b1);
        add_row(ACT_MAKE, SC_KEY_F5, 14'h000, 1'b0, 4'h7, 1'b1);
        add_row(ACT_BREAK, SC_KEY_F5, 14'h000, 1'b0, 4'h7, 1'b0);
        // parity error on D is dropped, clean D gets through
        add_row(ACT_BAD, SC_KEY_D, 14'h000, 1'b0, 4'h7, 1'b0);
        add_row(ACT_MAKE, SC_KEY_D, 14'h010, 1'b0, 4'h7, 1'b0);
        add_row(ACT_BREAK, SC_KEY_D, 14'h000, 1'b0, 4'h7, 1'b0);

        // reset values mid-reset, then count core_rst cycles after release
        repeat (8) @(posedge clk_sys);
        #1;
        exp_in = merge_inputs('0, '0);
        if (game_in !== exp_in) report_mismatch("game_in", exp_in, game_in);
        if (game_pause !== 1'b0) report_mismatch("game_pause", 1'b0, game_pause);
        if (gfx_en !== 4'hF) report_mismatch("gfx_en", 4'hF, gfx_en);
        repeat (8) @(posedge clk_sys);
        #1;
        game_rst = 1'b0;
        rst_cnt  = 0;
        while (core_rst === 1'b1) begin
            @(posedge clk_sys);
            #1;
            rst_cnt++;
        end
        if (rst_cnt != CORE_RST_LEN) report_mismatch("core_rst length", CORE_RST_LEN, rst_cnt);
        if (errors == 0) ok_cnt++;
        $display("reset test: %s", (errors == 0) ? "ok" : "mismatch");

        joy = '0;
        for (int i = 0; i < N_ROWS; i++) begin
            err_before  = errors;
            rise_before = rise_cnt;
            case (tbl[i].act)
                ACT_JOY, ACT_JOY_RND: begin
                    joy = tbl[i].data;
                    if (tbl[i].act == ACT_JOY_RND) joy = $urandom & 20'h7FDFF;
                    board_joy1 = joy[9:0];
                    board_joy2 = joy[19:10];
                    // sync stage plus output register
                    repeat (2) @(posedge clk_sys);
                    #1;
                    exp_in = merge_inputs(joy, tbl[i].kb);
                    if (game_in !== exp_in) report_mismatch("game_in", exp_in, game_in);
                end
                ACT_MAKE: send_frame(tbl[i].data[7:0], 1'b0);
                ACT_BREAK: begin
                    send_frame(SC_BREAK, 1'b0);
                    send_frame(tbl[i].data[7:0], 1'b0);
                end
                ACT_EXT: begin
                    send_frame(SC_EXT, 1'b0);
                    send_frame(tbl[i].data[7:0], 1'b0);
                end
                ACT_BAD: send_frame(tbl[i].data[7:0], 1'b1);
                ACT_DIP: dip_flip = ~dip_flip;
                ACT_REQ: begin
                    rst_req = 1'b1;
                    @(posedge clk_sys);
                    #1;
                    rst_req = 1'b0;
                end
                ACT_DL: begin
                    downloading = 1'b1;
                    repeat (10) @(posedge clk_sys);
                    #1;
                    downloading = 1'b0;
                end
                default: ;
            endcase
            repeat (4) @(posedge clk_sys);
            #1;
            rst_cnt = 0;
            while (core_rst === 1'b1 && rst_cnt <= CORE_RST_LEN + 8) begin
                @(posedge clk_sys);
                #1;
                rst_cnt++;
            end
            if (core_rst !== 1'b0) begin
                $display("core_rst did not come back low after row %0d", i);
                errors++;
            end
            if ((rise_cnt != rise_before) !== tbl[i].rst_rise)
                report_mismatch("core_rst rise", tbl[i].rst_rise, rise_cnt != rise_before);
            exp_in = merge_inputs(joy, tbl[i].kb);
            if (game_in !== exp_in) report_mismatch("game_in", exp_in, game_in);
            if (game_pause !== tbl[i].pause) report_mismatch("game_pause", tbl[i].pause, game_pause);
            if (gfx_en !== tbl[i].gfx) report_mismatch("gfx_en", tbl[i].gfx, gfx_en);
            if (errors == err_before) ok_cnt++;
            $display("row %0d action %0d: %s", i, tbl[i].act,
                     (errors == err_before) ? "ok" : "mismatch");
        end

        $display("%0d of %0d tests ok, %0d mismatches", ok_cnt, N_ROWS + 1, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
// testbench clock source: free-running clk_sys with a 4 ns period
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_sys
);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

endmodule

// ==== src/board_ctrl_top.sv ====
// board control top: keyboard, joystick merge, settings and core reset wiring
`timescale 1ns/1ps

module board_ctrl_top import board_pkg::*; (
    input  logic             clk_sys,
    input  logic             game_rst,
    input  logic             downloading,
    input  logic             rst_req,
    input  logic             dip_flip,
    input  logic             ps2_clk,
    input  logic             ps2_data,
    input  logic [JOY_W-1:0] board_joy1,
    input  logic [JOY_W-1:0] board_joy2,
    output game_in_t         game_in,
    output logic             game_pause,
    output logic [3:0]       gfx_en,
    output logic             core_rst
);

    logic [7:0] code;
    logic       code_valid;
    key_state_t keys;
    logic       joy_pause;
    logic       soft_rst;

    // ps/2 bytes
    ps2_rx u_ps2_rx (
        .clk_sys(clk_sys), .game_rst(game_rst),
        .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .code(code), .code_valid(code_valid)
    );

    // bytes to held keys
    key_decode u_key_decode (
        .clk_sys(clk_sys), .game_rst(game_rst),
        .code(code), .code_valid(code_valid), .keys(keys)
    );

    input_merge u_input_merge (
        .clk_sys(clk_sys), .game_rst(game_rst),
        .board_joy1(board_joy1), .board_joy2(board_joy2), .keys(keys),
        .game_in(game_in), .joy_pause(joy_pause)
    );

    board_config u_board_config (
        .clk_sys(clk_sys), .game_rst(game_rst), .keys(keys), .joy_pause(joy_pause),
        .game_pause(game_pause), .gfx_en(gfx_en), .soft_rst(soft_rst)
    );

    // stretched reset for the emulated core
    reset_stretch u_reset_stretch (
        .clk_sys(clk_sys), .game_rst(game_rst), .downloading(downloading),
        .rst_req(rst_req), .dip_flip(dip_flip), .soft_rst(soft_rst),
        .core_rst(core_rst)
    );

endmodule

// ==== src/reset_stretch.sv ====
// core reset stretcher: any reset cause holds core_rst for a fixed number of cycles
`timescale 1ns/1ps

module reset_stretch import board_pkg::*; (
    input  logic clk_sys,
    input  logic game_rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic dip_flip,
    input  logic soft_rst,
    output logic core_rst
);

    logic                      last_dip_flip;
    logic                      trigger;
    logic [CORE_RST_CNT_W-1:0] rst_cnt;

    // board reset counts as a cause too
    assign trigger = game_rst | downloading | rst_req | soft_rst
                     | (dip_flip != last_dip_flip);

    always_ff @(posedge clk_sys) begin
        last_dip_flip <= dip_flip;
        if (trigger) begin
            // reload, hold from this edge on
            rst_cnt  <= CORE_RST_CNT_W'(CORE_RST_LEN);
            core_rst <= 1'b1;
        end else if (rst_cnt != '0) begin
            rst_cnt  <= rst_cnt - 1'b1;
            // release on the LEN-th edge after the last trigger
            core_rst <= (rst_cnt > CORE_RST_CNT_W'(1));
        end else begin
            core_rst <= 1'b0;
        end
    end

endmodule

// ==== src/board_config.sv ====
// board settings: pause and graphics-layer toggles, soft reset pulse from the F5 key
`timescale 1ns/1ps

module board_config import board_pkg::*; (
    input  logic       clk_sys,
    input  logic       game_rst,
    input  key_state_t keys,
    input  logic       joy_pause,
    output logic       game_pause,
    output logic [3:0] gfx_en,
    output logic       soft_rst
);

    // previous levels for edge detection
    logic       last_pause;
    logic       last_joy_pause;
    logic       last_reset;
    logic [3:0] last_gfx;
    logic       pause_rise;
    logic [3:0] gfx_rise;

    // key or stick, either one flips pause
    assign pause_rise = (keys.pause & ~last_pause) | (joy_pause & ~last_joy_pause);
    assign gfx_rise   = keys.gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            last_pause     <= 1'b0;
            last_joy_pause <= 1'b0;
            last_reset     <= 1'b0;
            last_gfx       <= '0;
            game_pause     <= 1'b0;
            // all layers shown after reset
            gfx_en         <= '1;
            soft_rst       <= 1'b0;
        end else begin
            last_pause     <= keys.pause;
            last_joy_pause <= joy_pause;
            last_reset     <= keys.reset;
            last_gfx       <= keys.gfx;
            // single cycle, press only
            soft_rst       <= keys.reset & ~last_reset;
            if (pause_rise) begin
                game_pause <= ~game_pause;
            end
            for (int i = 0; i < 4; i++) begin
                if (gfx_rise[i]) begin
                    gfx_en[i] <= ~gfx_en[i];
                end
            end
        end
    end

endmodule

// ==== src/input_merge.sv ====
// input merge: syncs board joysticks, ORs in keyboard levels, drives game polarity
`timescale 1ns/1ps

module input_merge import board_pkg::*; (
    input  logic             clk_sys,
    input  logic             game_rst,
    input  logic [JOY_W-1:0] board_joy1,
    input  logic [JOY_W-1:0] board_joy2,
    input  key_state_t       keys,
    output game_in_t         game_in,
    output logic             joy_pause
);

    logic [JOY_W-1:0] joy1_sync;
    logic [JOY_W-1:0] joy2_sync;

    // either stick can request pause
    assign joy_pause = joy1_sync[JOY_PAUSE] | joy2_sync[JOY_PAUSE];

    // single sync stage on the board sticks
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            joy1_sync <= '0;
            joy2_sync <= '0;
        end else begin
            joy1_sync <= board_joy1;
            joy2_sync <= board_joy2;
        end
    end

    // output register, everything flipped to game polarity
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_in <= {$bits(game_in_t){INPUTS_ACTIVE_LOW}};
        end else begin
            // keyboard only drives player 1
            game_in.joy1    <= (joy1_sync | keys.joy1) ^ {JOY_W{INPUTS_ACTIVE_LOW}};
            game_in.joy2    <= joy2_sync ^ {JOY_W{INPUTS_ACTIVE_LOW}};
            // index 1 is player 2
            game_in.coin    <= ({joy2_sync[JOY_COIN], joy1_sync[JOY_COIN]} | keys.coin)
                               ^ {2{INPUTS_ACTIVE_LOW}};
            game_in.start   <= ({joy2_sync[JOY_START], joy1_sync[JOY_START]} | keys.start)
                               ^ {2{INPUTS_ACTIVE_LOW}};
            // service only exists on the keyboard
            game_in.service <= keys.service ^ INPUTS_ACTIVE_LOW;
        end
    end

endmodule

// ==== src/key_decode.sv ====
// keyboard decoder: tracks break/extended prefixes and holds mapped key levels
`timescale 1ns/1ps

module key_decode import board_pkg::*; (
    input  logic       clk_sys,
    input  logic       game_rst,
    input  logic [7:0] code,
    input  logic       code_valid,
    output key_state_t keys
);

    // pending prefix
    typedef enum logic [1:0] {
        KD_IDLE,
        KD_BREAK,
        KD_EXT
    } kd_state_e;

    kd_state_e pend;
    logic      level;

    // make sets, break clears
    assign level = (pend != KD_BREAK);

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            pend <= KD_IDLE;
            keys <= '0;
        end else if (code_valid) begin
            if (code == SC_EXT) begin
                pend <= KD_EXT;
            end else if (code == SC_BREAK) begin
                // extended release stays ignored
                pend <= (pend == KD_EXT) ? KD_EXT : KD_BREAK;
            end else begin
                pend <= KD_IDLE;
                // extended keys are not mapped
                if (pend != KD_EXT) begin
                    case (scan_code_e'(code))
                        SC_KEY_D:  keys.joy1[JOY_RIGHT] <= level;
                        SC_KEY_A:  keys.joy1[JOY_LEFT]  <= level;
                        SC_KEY_S:  keys.joy1[JOY_DOWN]  <= level;
                        SC_KEY_W:  keys.joy1[JOY_UP]    <= level;
                        SC_KEY_J:  keys.joy1[JOY_BUT1]  <= level;
                        SC_KEY_K:  keys.joy1[JOY_BUT2]  <= level;
                        SC_KEY_L:  keys.joy1[JOY_BUT3]  <= level;
                        SC_KEY_5:  keys.coin[0]         <= level;
                        SC_KEY_6:  keys.coin[1]         <= level;
                        SC_KEY_1:  keys.start[0]        <= level;
                        SC_KEY_2:  keys.start[1]        <= level;
                        SC_KEY_P:  keys.pause           <= level;
                        SC_KEY_9:  keys.service         <= level;
                        SC_KEY_F5: keys.reset           <= level;
                        SC_KEY_F1: keys.gfx[0]          <= level;
                        SC_KEY_F2: keys.gfx[1]          <= level;
                        SC_KEY_F3: keys.gfx[2]          <= level;
                        SC_KEY_F4: keys.gfx[3]          <= level;
                        // unknown code, only the prefix is consumed
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== src/ps2_rx.sv ====
// ps/2 receiver that samples the keyboard lines and emits parity-checked scan-code bytes
`timescale 1ns/1ps

module ps2_rx import board_pkg::*; (
    input  logic       clk_sys,
    input  logic       game_rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] code,
    output logic       code_valid
);

    // synchronizer chains idle high
    logic [PS2_SYNC_LEN-1:0] clk_sync;
    logic [PS2_SYNC_LEN-1:0] data_sync;
    logic                    clk_prev;
    logic                    clk_fall;
    logic                    data_s;

    // frame bits are start, 8 data, parity and stop
    // only the last ten need keeping between edges
    logic [9:0]              frame;
    logic [10:0]             next_frame;
    logic [3:0]              bit_cnt;
    logic [PS2_IDLE_W-1:0]   idle_cnt;
    logic                    frame_ok;

    assign data_s     = data_sync[PS2_SYNC_LEN-1];
    assign clk_fall   = clk_prev & ~clk_sync[PS2_SYNC_LEN-1];
    // lsb arrives first so new bits enter at the top
    assign next_frame = {data_s, frame};
    // start low, odd parity over data+parity, stop high
    assign frame_ok   = ~next_frame[0] & (^next_frame[9:1]) & next_frame[10];

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            clk_sync   <= '1;
            data_sync  <= '1;
            clk_prev   <= 1'b1;
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            code_valid <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[PS2_SYNC_LEN-2:0], ps2_clk};
            data_sync  <= {data_sync[PS2_SYNC_LEN-2:0], ps2_data};
            clk_prev   <= clk_sync[PS2_SYNC_LEN-1];
            code_valid <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                frame    <= next_frame[10:1];
                if (bit_cnt == 4'd10) begin
                    // eleventh bit completes the frame and bad ones just vanish
                    bit_cnt    <= '0;
                    code       <= next_frame[8:1];
                    code_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (idle_cnt == PS2_IDLE_W'(PS2_IDLE_LEN - 1)) begin
                // line quiet too long so the partial frame is dropped
                bit_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== src/board_pkg.sv ====
// board control package: shared key/input structs, scan codes and sizing constants
package board_pkg;

    // joystick word width and layout (three-button arcade panel)
    localparam int JOY_W = 10;
    typedef enum logic [3:0] {
        JOY_RIGHT = 4'd0, JOY_LEFT = 4'd1, JOY_DOWN = 4'd2, JOY_UP = 4'd3,
        JOY_BUT1 = 4'd4, JOY_BUT2 = 4'd5, JOY_BUT3 = 4'd6,
        JOY_COIN = 4'd7, JOY_START = 4'd8, JOY_PAUSE = 4'd9
    } joy_bit_e;

    // ps/2 set-2 make codes that the board understands
    typedef enum logic [7:0] {
        SC_KEY_D = 8'h23, SC_KEY_A = 8'h1C, SC_KEY_S = 8'h1B, SC_KEY_W = 8'h1D,
        SC_KEY_J = 8'h3B, SC_KEY_K = 8'h42, SC_KEY_L = 8'h4B,
        SC_KEY_5 = 8'h2E, SC_KEY_6 = 8'h36, SC_KEY_1 = 8'h16, SC_KEY_2 = 8'h1E,
        SC_KEY_P = 8'h4D, SC_KEY_9 = 8'h46, SC_KEY_F5 = 8'h03,
        SC_KEY_F1 = 8'h05, SC_KEY_F2 = 8'h06, SC_KEY_F3 = 8'h04, SC_KEY_F4 = 8'h0C,
        SC_BREAK = 8'hF0, SC_EXT = 8'hE0
    } scan_code_e;

    // held keyboard levels, active high
    typedef struct packed {
        logic [JOY_W-1:0] joy1;
        logic [1:0]       coin;
        logic [1:0]       start;
        logic             pause;
        logic             service;
        logic             reset;
        logic [3:0]       gfx;
    } key_state_t;

    // game-facing inputs, already in game polarity
    typedef struct packed {
        logic [JOY_W-1:0] joy1;
        logic [JOY_W-1:0] joy2;
        logic [1:0]       coin;
        logic [1:0]       start;
        logic             service;
    } game_in_t;

    localparam logic INPUTS_ACTIVE_LOW = 1'b1;
    localparam int   CORE_RST_LEN      = 64;
    localparam int   CORE_RST_CNT_W    = $clog2(CORE_RST_LEN + 1);
    localparam int   PS2_SYNC_LEN      = 2;
    localparam int   PS2_IDLE_LEN      = 1024;
    localparam int   PS2_IDLE_W        = $clog2(PS2_IDLE_LEN);

endpackage
